// ==== soc_bus_pkg.sv ====
// Wishbone bus widths, request/response structs, slave select type, address map, GPIO map
`default_nettype none

package soc_bus_pkg;

  // ====================================================================
  // Bus widths
  // ====================================================================
  localparam int WB_ADDR_W = 32;
  localparam int WB_DATA_W = 32;
  // One select bit per byte lane
  localparam int WB_SEL_W  = WB_DATA_W / 8;

  // Master to slave
  typedef struct packed {
    logic [WB_ADDR_W-1:0] adr;
    logic [WB_DATA_W-1:0] dat;
    logic [WB_SEL_W-1:0]  sel;
    logic                 we;
    logic                 cyc;
    logic                 stb;
  } wb_req_t;

  // Slave to master, ack and err are single-cycle pulses
  typedef struct packed {
    logic [WB_DATA_W-1:0] dat;
    logic                 ack;
    logic                 err;
  } wb_rsp_t;

  // Target of the current transfer
  typedef enum logic [1:0] {
    SEL_IMEM = 2'd0,
    SEL_DMEM = 2'd1,
    SEL_GPIO = 2'd2,
    SEL_NONE = 2'd3
  } slave_sel_e;

  // ====================================================================
  // Address map, decoded on adr[31:28]
  // ====================================================================
  localparam logic [3:0] IMEM_BASE_NIB = 4'h0;
  localparam logic [3:0] DMEM_BASE_NIB = 4'h2;
  localparam logic [3:0] GPIO_BASE_NIB = 4'h8;

  // GPIO register offsets within the block, on adr[7:0]
  localparam logic [7:0] GPIO_OUT_OFS = 8'h00;
  localparam logic [7:0] GPIO_EN_OFS  = 8'h04;
  localparam logic [7:0] GPIO_IN_OFS  = 8'h08;

  // Number of GPIO pins
  localparam int GPIO_W = 24;

endpackage : soc_bus_pkg

`default_nettype wire

// ==== soc_core_pkg.sv ====
// Core memory request struct, load/store width codes, memory sizes, boot ROM region
`default_nettype none

package soc_core_pkg;

  // Core register width
  localparam int XLEN = 32;

  // RV32I load/store funct3 encodings
  typedef enum logic [2:0] {
    OP_B  = 3'b000,
    OP_H  = 3'b001,
    OP_W  = 3'b010,
    OP_BU = 3'b100,
    OP_HU = 3'b101
  } mem_op_e;

  // Memory stage request, held by the core while stalled
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            read;
    logic            write;
    mem_op_e         op;
  } mem_req_t;

  // ====================================================================
  // Memory sizes and boot region
  // ====================================================================
  // pc[31:12] all ones selects the boot ROM, 0xFFFFF000 and up
  localparam logic [19:0] BOOT_REGION_NIB = 20'hFFFFF;
  localparam int BOOT_ROM_WORDS = 16;
  localparam int DMEM_WORDS     = 128;
  localparam int IMEM_WORDS     = 1024;

endpackage : soc_core_pkg

`default_nettype wire

// ==== wb_master_bridge.sv ====
// Wishbone master bridge: core request to bus transfer, lane steering, load extension
`default_nettype none
`timescale 1ns/1ps

module wb_master_bridge (
  input  wire                     clk,
  input  wire                     rst_n_i,
  input  wire soc_core_pkg::mem_req_t req_i,
  input  wire soc_bus_pkg::wb_rsp_t   rsp_i,
  output soc_bus_pkg::wb_req_t    wb_o,
  output logic [31:0]             rdata_o,
  output logic                    stall_o
);

  import soc_bus_pkg::*;
  import soc_core_pkg::*;

  logic                 pending;
  logic                 done;
  logic [1:0]           ofs;
  logic [WB_SEL_W-1:0]  sel;
  logic [WB_DATA_W-1:0] wdat;
  logic [WB_DATA_W-1:0] shifted;

  // Request still open until the slave or decoder terminates it
  assign pending = req_i.read | req_i.write;
  assign done    = rsp_i.ack | rsp_i.err;
  assign ofs     = req_i.addr[1:0];

  // ====================================================================
  // Byte lanes and write data steering
  // ====================================================================
  always_comb begin
    case (req_i.op)
      OP_B, OP_BU: begin
        sel  = WB_SEL_W'(4'b0001 << ofs);
        // Byte copied to every lane, sel picks the live one
        wdat = {4{req_i.wdata[7:0]}};
      end
      OP_H, OP_HU: begin
        sel  = WB_SEL_W'(4'b0011 << {ofs[1], 1'b0});
        wdat = {2{req_i.wdata[15:0]}};
      end
      default: begin
        sel  = '1;
        wdat = req_i.wdata;
      end
    endcase
  end

  // Strobe drops on the ack/err cycle so each request is one transfer
  always_comb begin
    wb_o.adr = req_i.addr;
    wb_o.dat = wdat;
    wb_o.sel = sel;
    wb_o.we  = req_i.write;
    wb_o.cyc = pending & ~done;
    wb_o.stb = pending & ~done;
  end

  // Core waits until the termination cycle
  assign stall_o = pending & ~done;

  // ====================================================================
  // Load data extraction and extension
  // ====================================================================
  // Addressed byte or half moved down to bit 0
  assign shifted = rsp_i.dat >> {ofs, 3'b000};

  always_comb begin
    if (rsp_i.err) begin
      // Error termination reads as zero
      rdata_o = '0;
    end else begin
      case (req_i.op)
        OP_B:    rdata_o = {{24{shifted[7]}}, shifted[7:0]};
        OP_BU:   rdata_o = {24'h0, shifted[7:0]};
        OP_H:    rdata_o = {{16{shifted[15]}}, shifted[15:0]};
        OP_HU:   rdata_o = {16'h0, shifted[15:0]};
        default: rdata_o = rsp_i.dat;
      endcase
    end
  end

  // Core must not issue misaligned half or word accesses
  a_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
    pending |-> ((req_i.op inside {OP_H, OP_HU}) ? !req_i.addr[0] :
                 (req_i.op == OP_W) ? (req_i.addr[1:0] == 2'b00) : 1'b1));

  // Slaves and decoder never terminate with both ack and err
  a_ack_err: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(rsp_i.ack && rsp_i.err));

endmodule : wb_master_bridge

`default_nettype wire

// ==== wb_addr_decoder.sv ====
// Wishbone address decoder: slave select, request fan-out, response mux, error termination
`default_nettype none
`timescale 1ns/1ps

module wb_addr_decoder (
  input  wire                   clk,
  input  wire                   rst_n_i,
  input  wire soc_bus_pkg::wb_req_t m_req_i,
  input  wire soc_bus_pkg::wb_rsp_t imem_rsp_i,
  input  wire soc_bus_pkg::wb_rsp_t dmem_rsp_i,
  input  wire soc_bus_pkg::wb_rsp_t gpio_rsp_i,
  output soc_bus_pkg::wb_rsp_t  m_rsp_o,
  output soc_bus_pkg::wb_req_t  imem_req_o,
  output soc_bus_pkg::wb_req_t  dmem_req_o,
  output soc_bus_pkg::wb_req_t  gpio_req_o
);

  import soc_bus_pkg::*;

  slave_sel_e sel;
  logic       err_q;

  // Pass a request on with cyc/stb kept only for the chosen slave
  function automatic wb_req_t gate_req(input wb_req_t r, input logic en);
    wb_req_t g;
    g     = r;
    g.cyc = r.cyc & en;
    g.stb = r.stb & en;
    return g;
  endfunction

  // Top nibble picks the target
  always_comb begin
    case (m_req_i.adr[WB_ADDR_W-1 -: 4])
      IMEM_BASE_NIB: sel = SEL_IMEM;
      DMEM_BASE_NIB: sel = SEL_DMEM;
      GPIO_BASE_NIB: sel = SEL_GPIO;
      default:       sel = SEL_NONE;
    endcase
  end

  assign imem_req_o = gate_req(m_req_i, sel == SEL_IMEM);
  assign dmem_req_o = gate_req(m_req_i, sel == SEL_DMEM);
  assign gpio_req_o = gate_req(m_req_i, sel == SEL_GPIO);

  // Unmapped address, err one cycle after stb like a real slave
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= m_req_i.cyc & m_req_i.stb & (sel == SEL_NONE) & ~err_q;
    end
  end

  // Response from the slave the address points at
  always_comb begin
    case (sel)
      SEL_IMEM: m_rsp_o = imem_rsp_i;
      SEL_DMEM: m_rsp_o = dmem_rsp_i;
      SEL_GPIO: m_rsp_o = gpio_rsp_i;
      default: begin
        m_rsp_o.dat = '0;
        m_rsp_o.ack = 1'b0;
        m_rsp_o.err = err_q;
      end
    endcase
  end

  // Never more than one slave strobed
  a_one_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({imem_req_o.stb, dmem_req_o.stb, gpio_req_o.stb}));

endmodule : wb_addr_decoder

`default_nettype wire

// ==== wb_sram.sv ====
// Single-port word RAM Wishbone slave with byte lane writes and registered read
`default_nettype none
`timescale 1ns/1ps

module wb_sram #(
  parameter int DEPTH = 128
) (
  input  wire                   clk,
  input  wire                   rst_n_i,
  input  wire soc_bus_pkg::wb_req_t req_i,
  output soc_bus_pkg::wb_rsp_t  rsp_o
);

  import soc_bus_pkg::*;

  // Word index width, DEPTH a power of two
  localparam int AW = $clog2(DEPTH);

  logic [WB_DATA_W-1:0] mem [DEPTH];
  logic [AW-1:0]        idx;
  logic                 acc;
  logic                 ack_q;
  logic [WB_DATA_W-1:0] rdat_q;

  // Word address wraps modulo DEPTH
  assign idx = req_i.adr[AW+1:2];
  // First cycle of a strobe only
  assign acc = req_i.cyc & req_i.stb & ~ack_q;

  // ====================================================================
  // Storage
  // ====================================================================
  always_ff @(posedge clk) begin
    if (acc && req_i.we) begin
      for (int i = 0; i < WB_SEL_W; i++) begin
        // Only enabled lanes change
        if (req_i.sel[i]) begin
          mem[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
        end
      end
    end
  end

  // Read data lands together with ack
  always_ff @(posedge clk) begin
    if (acc && !req_i.we) begin
      rdat_q <= mem[idx];
    end
  end

  // Single-cycle ack
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc;
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_q;
  // RAM never faults
  assign rsp_o.err = 1'b0;

endmodule : wb_sram

`default_nettype wire

// ==== wb_gpio.sv ====
// GPIO Wishbone slave: output and enable registers, two-flop input synchronizer
`default_nettype none
`timescale 1ns/1ps

module wb_gpio (
  input  wire                               clk,
  input  wire                               rst_n_i,
  input  wire soc_bus_pkg::wb_req_t         req_i,
  input  wire [soc_bus_pkg::GPIO_W-1:0]     gpio_i,
  output soc_bus_pkg::wb_rsp_t              rsp_o,
  output logic [soc_bus_pkg::GPIO_W-1:0]    gpio_o,
  output logic [soc_bus_pkg::GPIO_W-1:0]    gpio_en_o
);

  import soc_bus_pkg::*;

  logic [GPIO_W-1:0]    out_q;
  logic [GPIO_W-1:0]    en_q;
  logic [GPIO_W-1:0]    in_meta;
  logic [GPIO_W-1:0]    in_sync;
  logic [7:0]           ofs;
  logic                 acc;
  logic                 ack_q;
  logic [WB_DATA_W-1:0] rdat_q;

  assign ofs = req_i.adr[7:0];
  assign acc = req_i.cyc & req_i.stb & ~ack_q;

  // Byte-lane merge into a GPIO register
  function automatic logic [GPIO_W-1:0] merge(input logic [GPIO_W-1:0] old,
                                              input logic [WB_DATA_W-1:0] wdat,
                                              input logic [WB_SEL_W-1:0] sel);
    logic [GPIO_W-1:0] r;
    r = old;
    for (int i = 0; i < GPIO_W / 8; i++) begin
      if (sel[i]) r[8*i +: 8] = wdat[8*i +: 8];
    end
    return r;
  endfunction

  // ====================================================================
  // Registers
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      en_q  <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc;
      if (acc && req_i.we) begin
        // Input offset is read-only, writes there are dropped
        if (ofs == GPIO_OUT_OFS) out_q <= merge(out_q, req_i.dat, req_i.sel);
        if (ofs == GPIO_EN_OFS)  en_q  <= merge(en_q, req_i.dat, req_i.sel);
      end
    end
  end

  // Pins are asynchronous to clk
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= gpio_i;
      in_sync <= in_meta;
    end
  end

  // Read mux, unused offsets give zero
  always_ff @(posedge clk) begin
    if (acc && !req_i.we) begin
      case (ofs)
        GPIO_OUT_OFS: rdat_q <= WB_DATA_W'(out_q);
        GPIO_EN_OFS:  rdat_q <= WB_DATA_W'(en_q);
        GPIO_IN_OFS:  rdat_q <= WB_DATA_W'(in_sync);
        default:      rdat_q <= '0;
      endcase
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;

  assign gpio_o    = out_q;
  assign gpio_en_o = en_q;

endmodule : wb_gpio

`default_nettype wire

// ==== instr_fetch.sv ====
// Instruction fetch: IMEM with bus and fetch ports, boot ROM, registered instruction select
`default_nettype none
`timescale 1ns/1ps

module instr_fetch (
  input  wire                   clk,
  input  wire                   rst_n_i,
  input  wire soc_bus_pkg::wb_req_t bus_req_i,
  input  wire [31:0]            pc_i,
  input  wire                   if_id_en_i,
  output soc_bus_pkg::wb_rsp_t  bus_rsp_o,
  output logic [31:0]           inst_o
);

  import soc_bus_pkg::*;
  import soc_core_pkg::*;

  localparam int IAW = $clog2(IMEM_WORDS);
  localparam int RAW = $clog2(BOOT_ROM_WORDS);

  logic [WB_DATA_W-1:0] imem [IMEM_WORDS];
  logic [31:0]          rom  [BOOT_ROM_WORDS];

  logic [IAW-1:0]       bus_idx;
  logic                 acc;
  logic                 ack_q;
  logic [WB_DATA_W-1:0] bus_rdat_q;
  logic [31:0]          imem_inst_q;
  logic [31:0]          rom_inst_q;
  logic                 boot_q;

  // Boot code image
  initial begin
    $readmemh("boot_rom.hex", rom);
  end

  // ====================================================================
  // Bus port
  // ====================================================================
  assign bus_idx = bus_req_i.adr[IAW+1:2];
  assign acc     = bus_req_i.cyc & bus_req_i.stb & ~ack_q;

  always_ff @(posedge clk) begin
    if (acc && bus_req_i.we) begin
      for (int i = 0; i < WB_SEL_W; i++) begin
        if (bus_req_i.sel[i]) begin
          imem[bus_idx][8*i +: 8] <= bus_req_i.dat[8*i +: 8];
        end
      end
    end
    if (acc && !bus_req_i.we) begin
      bus_rdat_q <= imem[bus_idx];
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc;
    end
  end

  assign bus_rsp_o.dat = bus_rdat_q;
  assign bus_rsp_o.ack = ack_q;
  assign bus_rsp_o.err = 1'b0;

  // ====================================================================
  // Fetch port
  // ====================================================================
  // Both sources read every enabled cycle, select registered alongside
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      imem_inst_q <= '0;
      boot_q      <= 1'b0;
    end else if (if_id_en_i) begin
      imem_inst_q <= imem[pc_i[IAW+1:2]];
      boot_q      <= (pc_i[31:12] == BOOT_REGION_NIB);
    end
  end

  // Only seen when boot_q is set
  always_ff @(posedge clk) begin
    if (if_id_en_i) begin
      rom_inst_q <= rom[pc_i[RAW+1:2]];
    end
  end

  // Holds while the pipeline is frozen
  assign inst_o = boot_q ? rom_inst_q : imem_inst_q;

endmodule : instr_fetch

`default_nettype wire

// ==== soc_fabric.sv ====
// SoC bus fabric top: master bridge, address decoder, data RAM, GPIO and fetch unit
`default_nettype none
`timescale 1ns/1ps

module soc_fabric (
  input  wire                               clk,
  input  wire                               rst_n_i,
  input  wire soc_core_pkg::mem_req_t       mem_req_i,
  input  wire [31:0]                        pc_i,
  input  wire                               if_id_en_i,
  input  wire [soc_bus_pkg::GPIO_W-1:0]     gpio_i,
  output logic [31:0]                       mem_rdata_o,
  output logic                              stall_o,
  output logic [31:0]                       inst_o,
  output logic [soc_bus_pkg::GPIO_W-1:0]    gpio_o,
  output logic [soc_bus_pkg::GPIO_W-1:0]    gpio_en_o
);

  import soc_bus_pkg::*;
  import soc_core_pkg::*;

  // Master side
  wb_req_t m_req;
  wb_rsp_t m_rsp;
  // Slave side, one pair per target
  wb_req_t imem_req;
  wb_rsp_t imem_rsp;
  wb_req_t dmem_req;
  wb_rsp_t dmem_rsp;
  wb_req_t gpio_req;
  wb_rsp_t gpio_rsp;

  // ====================================================================
  // Master and interconnect
  // ====================================================================
  wb_master_bridge bridge_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (mem_req_i),
    .rsp_i   (m_rsp),
    .wb_o    (m_req),
    .rdata_o (mem_rdata_o),
    .stall_o (stall_o)
  );

  wb_addr_decoder decoder_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .m_req_i    (m_req),
    .imem_rsp_i (imem_rsp),
    .dmem_rsp_i (dmem_rsp),
    .gpio_rsp_i (gpio_rsp),
    .m_rsp_o    (m_rsp),
    .imem_req_o (imem_req),
    .dmem_req_o (dmem_req),
    .gpio_req_o (gpio_req)
  );

  // ====================================================================
  // Slaves
  // ====================================================================
  wb_sram #(
    .DEPTH (DMEM_WORDS)
  ) dmem_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (dmem_req),
    .rsp_o   (dmem_rsp)
  );

  wb_gpio gpio_inst (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .req_i     (gpio_req),
    .gpio_i    (gpio_i),
    .rsp_o     (gpio_rsp),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o)
  );

  // IMEM bus port plus the fetch path
  instr_fetch fetch_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .bus_req_i  (imem_req),
    .pc_i       (pc_i),
    .if_id_en_i (if_id_en_i),
    .bus_rsp_o  (imem_rsp),
    .inst_o     (inst_o)
  );

endmodule : soc_fabric

`default_nettype wire

// ==== tb_soc_fabric.sv ====
// SoC bus fabric testbench with stimulus tasks, reference model and checking assertions
`default_nettype none
`timescale 1ns/1ps

module tb_soc_fabric;

  import soc_bus_pkg::*;
  import soc_core_pkg::*;

  // ====================================================================
  // Run parameters
  // ====================================================================
  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 4;
  localparam int N_RAND       = 12;
  localparam int N_IMEM       = 8;
  localparam int ACCESS_LIMIT = 8;
  // Two cycles per bus access and per fetch plus GPIO and hold waits
  localparam int BUS_OPS     = 2 * N_RAND + 30 + 10 + 2 * N_IMEM;
  localparam int FETCH_OPS   = BOOT_ROM_WORDS + N_IMEM + 1;
  localparam int TEST_CYCLES = RESET_CYCLES + 2 * BUS_OPS + 2 * FETCH_OPS + 20;
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

  logic              clk;
  logic              rst_n_i;
  mem_req_t          mem_req;
  logic [31:0]       pc_i;
  logic              if_id_en_i;
  logic [GPIO_W-1:0] gpio_i;
  logic [31:0]       mem_rdata_o;
  logic              stall_o;
  logic [31:0]       inst_o;
  logic [GPIO_W-1:0] gpio_o;
  logic [GPIO_W-1:0] gpio_en_o;

  // Reference model storage
  logic [31:0] dmem_m [DMEM_WORDS];
  logic [31:0] imem_m [IMEM_WORDS];
  logic [31:0] rom_m  [BOOT_ROM_WORDS];
  int          checks = 0;
  int          errors = 0;

  soc_fabric soc_fabric_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .mem_req_i   (mem_req),
    .pc_i        (pc_i),
    .if_id_en_i  (if_id_en_i),
    .gpio_i      (gpio_i),
    .mem_rdata_o (mem_rdata_o),
    .stall_o     (stall_o),
    .inst_o      (inst_o),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Hard stop if the sequence gets stuck
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  // ====================================================================
  // Protocol assertions
  // ====================================================================
  // Each transfer stalls the core for one cycle only
  a_one_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_o |=> !stall_o)
    else begin
      errors++;
      $display("[ERROR] %0t ns: stall_o high for more than one cycle", $time);
    end

  // Frozen pipeline keeps the fetched word
  a_inst_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    !if_id_en_i |=> $stable(inst_o))
    else begin
      errors++;
      $display("[ERROR] %0t ns: inst_o changed while if_id_en_i was low", $time);
    end

  // ====================================================================
  // Reference model
  // ====================================================================
  // Store merge by RISC-V width rules
  function automatic logic [31:0] store_ref(input logic [31:0] old, input mem_op_e op,
                                            input logic [1:0] ofs, input logic [31:0] wdata);
    logic [31:0] r;
    r = old;
    case (op)
      OP_B, OP_BU: r[8 * ofs +: 8] = wdata[7:0];
      OP_H, OP_HU: r[16 * ofs[1] +: 16] = wdata[15:0];
      default:     r = wdata;
    endcase
    return r;
  endfunction

  // Load pick and extension
  function automatic logic [31:0] load_ref(input logic [31:0] word, input mem_op_e op,
                                           input logic [1:0] ofs);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8 * ofs +: 8];
    h = word[16 * ofs[1] +: 16];
    case (op)
      OP_B:    return {{24{b[7]}}, b};
      OP_BU:   return {24'h0, b};
      OP_H:    return {{16{h[15]}}, h};
      OP_HU:   return {16'h0, h};
      default: return word;
    endcase
  endfunction

  function automatic logic [31:0] dmem_addr(input int idx, input logic [1:0] ofs);
    return {DMEM_BASE_NIB, 19'h0, 7'(idx), ofs};
  endfunction

  function automatic logic [31:0] imem_addr(input int idx);
    return {IMEM_BASE_NIB, 16'h0, 10'(idx), 2'b00};
  endfunction

  function automatic logic [31:0] gpio_addr(input logic [7:0] ofs);
    return {GPIO_BASE_NIB, 20'h0, ofs};
  endfunction

  // ====================================================================
  // Stimulus and checks
  // ====================================================================
  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else begin
      errors++;
      $display("[ERROR] %0t ns: %s gave %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic bus_access(input logic wr, input mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waits;
    mem_req.addr  = addr;
    mem_req.wdata = wdata;
    mem_req.read  = ~wr;
    mem_req.write = wr;
    mem_req.op    = op;
    waits = 0;
    // Stall and read data sampled mid-cycle
    @(negedge clk);
    while (stall_o && waits < ACCESS_LIMIT) begin
      waits++;
      @(negedge clk);
    end
    rdata = mem_rdata_o;
    if (stall_o) begin
      errors++;
      $display("Bus access to %h never completed, stall_o stayed high", addr);
    end else begin
      check_eq($sformatf("stall cycles @%h", addr), waits, 1);
    end
    @(posedge clk);
    #DRIVE_DLY;
    mem_req.read  = 1'b0;
    mem_req.write = 1'b0;
  endtask

  task automatic store_dmem(input mem_op_e op, input int idx, input logic [1:0] ofs,
                            input logic [31:0] wdata);
    logic [31:0] ignored;
    bus_access(1'b1, op, dmem_addr(idx, ofs), wdata, ignored);
    dmem_m[idx] = store_ref(dmem_m[idx], op, ofs, wdata);
  endtask

  task automatic load_dmem(input mem_op_e op, input int idx, input logic [1:0] ofs);
    logic [31:0] got;
    bus_access(1'b0, op, dmem_addr(idx, ofs), 32'h0, got);
    check_eq($sformatf("dmem %s @%h", op.name(), dmem_addr(idx, ofs)), got,
             load_ref(dmem_m[idx], op, ofs));
  endtask

  // One enabled cycle and a check of inst_o after the capture edge
  task automatic fetch_check(input logic [31:0] pc, input logic [31:0] exp);
    pc_i       = pc;
    if_id_en_i = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    if_id_en_i = 1'b0;
    @(negedge clk);
    check_eq($sformatf("fetch @%h", pc), inst_o, exp);
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  initial begin
    logic [31:0]       rnd;
    logic [31:0]       got;
    logic [31:0]       held;
    logic [GPIO_W-1:0] out_val;
    logic [GPIO_W-1:0] en_val;
    logic [GPIO_W-1:0] pin_val;
    int                widx [N_RAND];
    int                iidx [N_IMEM];
    int                seed;

    seed = $urandom(26);
    $readmemh("boot_rom.hex", rom_m);
    rst_n_i    = 1'b0;
    mem_req    = '0;
    pc_i       = '0;
    if_id_en_i = 1'b0;
    gpio_i     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n_i = 1'b1;

    // Reset state
    @(negedge clk);
    check_eq("stall_o after reset", {31'h0, stall_o}, 32'h0);
    check_eq("gpio_o after reset", {8'h0, gpio_o}, 32'h0);
    check_eq("gpio_en_o after reset", {8'h0, gpio_en_o}, 32'h0);
    check_eq("inst_o after reset", inst_o, 32'h0);
    @(posedge clk);
    #DRIVE_DLY;

    // Random word writes followed by reads
    for (int i = 0; i < N_RAND; i++) begin
      widx[i] = int'($urandom % DMEM_WORDS);
      store_dmem(OP_W, widx[i], 2'b00, $urandom);
    end
    for (int i = 0; i < N_RAND; i++) begin
      load_dmem(OP_W, widx[i], 2'b00);
    end

    // Byte lanes with the sign bit alternating across offsets
    for (int o = 0; o < 4; o++) begin
      store_dmem(OP_W, o, 2'b00, $urandom);
      rnd    = $urandom;
      rnd[7] = o[0];
      store_dmem(OP_B, o, 2'(o), rnd);
      load_dmem(OP_B, o, 2'(o));
      load_dmem(OP_BU, o, 2'(o));
      load_dmem(OP_W, o, 2'b00);
    end
    // Half lanes
    for (int o = 0; o < 4; o += 2) begin
      store_dmem(OP_W, 8 + o, 2'b00, $urandom);
      rnd     = $urandom;
      rnd[15] = o[1];
      store_dmem(OP_H, 8 + o, 2'(o), rnd);
      load_dmem(OP_H, 8 + o, 2'(o));
      load_dmem(OP_HU, 8 + o, 2'(o));
      load_dmem(OP_W, 8 + o, 2'b00);
    end

    // ====================================================================
    // GPIO
    // ====================================================================
    out_val = GPIO_W'($urandom);
    en_val  = GPIO_W'($urandom);
    bus_access(1'b1, OP_W, gpio_addr(GPIO_OUT_OFS), {8'h0, out_val}, got);
    bus_access(1'b1, OP_W, gpio_addr(GPIO_EN_OFS), {8'h0, en_val}, got);
    check_eq("gpio_o", {8'h0, gpio_o}, {8'h0, out_val});
    check_eq("gpio_en_o", {8'h0, gpio_en_o}, {8'h0, en_val});
    bus_access(1'b0, OP_W, gpio_addr(GPIO_OUT_OFS), 32'h0, got);
    check_eq("gpio out register", got, {8'h0, out_val});
    bus_access(1'b0, OP_W, gpio_addr(GPIO_EN_OFS), 32'h0, got);
    check_eq("gpio enable register", got, {8'h0, en_val});
    // Pins held three cycles through the synchronizer
    pin_val = GPIO_W'($urandom);
    gpio_i  = pin_val;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    bus_access(1'b0, OP_W, gpio_addr(GPIO_IN_OFS), 32'h0, got);
    check_eq("gpio input register", got, {8'h0, pin_val});
    // Input register ignores writes
    bus_access(1'b1, OP_W, gpio_addr(GPIO_IN_OFS), 32'hFFFF_FFFF, got);
    bus_access(1'b0, OP_W, gpio_addr(GPIO_IN_OFS), 32'h0, got);
    check_eq("gpio input after write", got, {8'h0, pin_val});
    bus_access(1'b0, OP_W, gpio_addr(8'h0C), 32'h0, got);
    check_eq("gpio unused offset", got, 32'h0);

    // Unmapped region at nibble 4
    bus_access(1'b0, OP_W, 32'h4000_0010, 32'h0, got);
    check_eq("unmapped load", got, 32'h0);
    bus_access(1'b1, OP_W, {4'h4, 19'h0, 7'(widx[0]), 2'b00}, 32'hDEAD_BEEF, got);
    load_dmem(OP_W, widx[0], 2'b00);
    bus_access(1'b0, OP_W, gpio_addr(GPIO_OUT_OFS), 32'h0, got);
    check_eq("gpio out after unmapped store", got, {8'h0, out_val});

    // ====================================================================
    // Instruction memory and fetch
    // ====================================================================
    for (int i = 0; i < N_IMEM; i++) begin
      iidx[i] = int'($urandom % IMEM_WORDS);
      rnd     = $urandom;
      bus_access(1'b1, OP_W, imem_addr(iidx[i]), rnd, got);
      imem_m[iidx[i]] = rnd;
    end
    for (int i = 0; i < N_IMEM; i++) begin
      bus_access(1'b0, OP_W, imem_addr(iidx[i]), 32'h0, got);
      check_eq($sformatf("imem bus read @%h", imem_addr(iidx[i])), got, imem_m[iidx[i]]);
    end
    for (int i = 0; i < N_IMEM; i++) begin
      fetch_check(imem_addr(iidx[i]), imem_m[iidx[i]]);
    end
    for (int k = 0; k < BOOT_ROM_WORDS; k++) begin
      fetch_check(32'hFFFF_F000 + 32'(k * 4), rom_m[k]);
    end
    // New pc without enable leaves the last boot word in place
    held = rom_m[BOOT_ROM_WORDS - 1];
    pc_i = imem_addr(iidx[0]);
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_eq("inst_o while fetch disabled", inst_o, held);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : tb_soc_fabric

`default_nettype wire

// ==== boot_rom.hex ====
// Boot ROM image: one 32-bit hex word per line, word 0 sits at 0xFFFFF000
00000013
200000b7
80000137
00100193
0030a023
0000a203
00412023
00112223
fe0218e3
00000297
01028293
00028067
deadbeef
0badc0de
12345678
8765a5a5

// ==== sources.f ====
soc_bus_pkg.sv
soc_core_pkg.sv
wb_master_bridge.sv
wb_addr_decoder.sv
wb_sram.sv
wb_gpio.sv
instr_fetch.sv
soc_fabric.sv
tb_soc_fabric.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SoC fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_soc_fabric \
  -f sources.f -o tb_soc_fabric > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_fabric > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Something failed" sim.log; then
  exit 1
fi
exit 0
